//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////////////////////////

// Bits held by one cache line
`define CACHE_LINE_BITS 64

// Sets per way
`define CACHE_SETS 4

// Bytes per line, and the byte offset that selects one of them
`define CACHE_LINE_BYTES (`CACHE_LINE_BITS / 8)
`define CACHE_OFFSET_BITS $clog2(`CACHE_LINE_BYTES)

// Address fields above the offset
`define CACHE_INDEX_BITS $clog2(`CACHE_SETS)
`define CACHE_TAG_BITS (32 - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

`endif

//--- design/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

	//////////////////////////////////////////////////////////////////////
	// Address views
	//////////////////////////////////////////////////////////////////////

	// address = tag | index | word select | byte in word
	typedef struct packed {
		logic [`CACHE_TAG_BITS-1:0]      tag;
		logic [`CACHE_INDEX_BITS-1:0]    index;
		logic [`CACHE_OFFSET_BITS-3:0]   word_sel;
		logic [1:0]                      byte_sel;
	} cache_fields_t;

	// Same word, read raw on the memory side or split inside the cache
	typedef union packed {
		logic [31:0]   raw;
		cache_fields_t fields;
	} cache_addr_t;

	//////////////////////////////////////////////////////////////////////
	// Port payloads
	//////////////////////////////////////////////////////////////////////

	// Processor request, held until hit
	typedef struct packed {
		cache_addr_t addr;
		logic        write;
		logic [3:0]  byte_en;
		logic [31:0] wdata;
	} cpu_req_t;

	// Write-back of one whole line
	typedef struct packed {
		logic [31:0]                 addr;
		logic [`CACHE_LINE_BITS-1:0] data;
	} mem_wr_t;

	// Line read request
	typedef struct packed {
		logic [31:0] addr;
	} mem_rd_t;

	// One bit per way
	typedef logic [3:0] way_mask_t;

endpackage

//--- design/cache_way.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_way (
	input  logic                          clk,
	input  logic                          reset,
	input  cache_pkg::cpu_req_t           req,
	input  logic                          access,
	input  logic                          fill,
	input  logic [`CACHE_LINE_BITS-1:0]   fill_line,
	input  logic [`CACHE_TAG_BITS-1:0]    fill_tag,
	input  logic [`CACHE_INDEX_BITS-1:0]  fill_index,
	output logic                          way_hit,
	output logic                          way_valid,
	output logic                          way_dirty,
	output logic [`CACHE_TAG_BITS-1:0]    way_tag,
	output logic [`CACHE_LINE_BITS-1:0]   way_line,
	output logic [31:0]                   word_out
);

	localparam int WORDS = `CACHE_LINE_BYTES / 4;

	// Per-set state of this way
	logic [`CACHE_SETS-1:0]        valid_bits;
	logic [`CACHE_SETS-1:0]        dirty_bits;
	logic [`CACHE_TAG_BITS-1:0]    tag_mem  [`CACHE_SETS];
	logic [`CACHE_LINE_BITS-1:0]   line_mem [`CACHE_SETS];

	logic [`CACHE_INDEX_BITS-1:0]  index;
	logic [31:0]                   cur_word;
	logic [31:0]                   merged_word;
	logic [`CACHE_LINE_BITS-1:0]   merged_line;

	//////////////////////////////////////////////////////////////////////
	// Lookup at the request's index
	//////////////////////////////////////////////////////////////////////

	assign index     = req.addr.fields.index;
	assign way_valid = valid_bits[index];
	assign way_dirty = dirty_bits[index];
	assign way_tag   = tag_mem[index];
	assign way_line  = line_mem[index];
	assign way_hit   = way_valid && (way_tag == req.addr.fields.tag);

	assign cur_word = way_line[req.addr.fields.word_sel * 32 +: 32];

	// Byte merge of the write data into the addressed word
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			if (req.byte_en[b])
				merged_word[b*8 +: 8] = req.wdata[b*8 +: 8];
			else
				merged_word[b*8 +: 8] = cur_word[b*8 +: 8];
		end
	end

	// Whole line with only the selected word replaced
	always_comb begin
		for (int w = 0; w < WORDS; w++) begin
			if (w == int'(req.addr.fields.word_sel))
				merged_line[w*32 +: 32] = merged_word;
			else
				merged_line[w*32 +: 32] = way_line[w*32 +: 32];
		end
	end

	// A write shows the word as it will be after the edge
	assign word_out = req.write ? merged_word : cur_word;

	//////////////////////////////////////////////////////////////////////
	// State update
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (fill) begin
			valid_bits[fill_index] <= 1'b1;
			dirty_bits[fill_index] <= 1'b0;
		end else if (access && req.write) begin
			dirty_bits[index] <= 1'b1;
		end
	end

	// Tag and data arrays
	always_ff @(posedge clk) begin
		if (fill) begin
			tag_mem[fill_index]  <= fill_tag;
			line_mem[fill_index] <= fill_line;
		end else if (access && req.write) begin
			line_mem[index] <= merged_line;
		end
	end

endmodule

//--- design/plru_tree.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module plru_tree (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`CACHE_INDEX_BITS-1:0]  index,
	input  logic                          touch,
	input  cache_pkg::way_mask_t          hit_ways,
	input  cache_pkg::way_mask_t          valid_ways,
	output cache_pkg::way_mask_t          victim
);

	// Bit 2 picks the half, bit 1 the way in 0/1, bit 0 the way in 2/3
	logic [2:0] tree_bits [`CACHE_SETS];
	logic [2:0] cur_bits;

	assign cur_bits = tree_bits[index];

	// Point the tree away from the way just used
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < `CACHE_SETS; s++)
				tree_bits[s] <= 3'b000;
		end else if (touch) begin
			case (hit_ways)
				4'b0001: tree_bits[index] <= {2'b11, cur_bits[0]};
				4'b0010: tree_bits[index] <= {2'b10, cur_bits[0]};
				4'b0100: tree_bits[index] <= {1'b0, cur_bits[1], 1'b1};
				4'b1000: tree_bits[index] <= {1'b0, cur_bits[1], 1'b0};
				default: tree_bits[index] <= cur_bits;
			endcase
		end
	end

	// Empty ways go first, lowest number wins
	always_comb begin
		if (!valid_ways[0])
			victim = 4'b0001;
		else if (!valid_ways[1])
			victim = 4'b0010;
		else if (!valid_ways[2])
			victim = 4'b0100;
		else if (!valid_ways[3])
			victim = 4'b1000;
		else begin
			case ({cur_bits[2], cur_bits[2] ? cur_bits[0] : cur_bits[1]})
				2'b00:   victim = 4'b0001;
				2'b01:   victim = 4'b0010;
				2'b10:   victim = 4'b0100;
				default: victim = 4'b1000;
			endcase
		end
	end

endmodule

//--- design/miss_controller.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module miss_controller (
	input  logic                          clk,
	input  logic                          reset,
	input  cache_pkg::cpu_req_t           req,
	input  logic                          miss,
	input  cache_pkg::way_mask_t          victim,
	input  logic                          victim_dirty,
	input  logic [`CACHE_TAG_BITS-1:0]    victim_tag,
	input  logic [`CACHE_LINE_BITS-1:0]   victim_line,
	input  logic                          mem_write_ack,
	input  logic                          mem_read_ack,
	input  logic [`CACHE_LINE_BITS-1:0]   mem_read_data,
	output logic                          mem_write_req,
	output cache_pkg::mem_wr_t            mem_wr,
	output logic                          mem_read_req,
	output cache_pkg::mem_rd_t            mem_rd,
	output cache_pkg::way_mask_t          fill,
	output logic [`CACHE_LINE_BITS-1:0]   fill_line,
	output logic [`CACHE_TAG_BITS-1:0]    fill_tag,
	output logic [`CACHE_INDEX_BITS-1:0]  fill_index
);

	import cache_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WRITE_BACK,
		READ,
		FILL
	} state_t;

	state_t      state;
	way_mask_t   victim_q;
	cache_addr_t wb_addr;
	cache_addr_t rd_addr;
	logic        start;

	// Only an idle controller takes a new miss
	assign start = (state == IDLE) && miss;

	//////////////////////////////////////////////////////////////////////
	// Line addresses, offset bits zero
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		wb_addr              = '0;
		wb_addr.fields.tag   = victim_tag;
		wb_addr.fields.index = req.addr.fields.index;

		rd_addr              = '0;
		rd_addr.fields.tag   = req.addr.fields.tag;
		rd_addr.fields.index = req.addr.fields.index;
	end

	// One-cycle write strobe into the chosen way
	assign fill = (state == FILL) ? victim_q : '0;

	//////////////////////////////////////////////////////////////////////
	// FSM and memory requests
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= IDLE;
			mem_write_req <= 1'b0;
			mem_read_req  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (miss) begin
						// Dirty victim goes out before the read
						if (victim_dirty) begin
							mem_write_req <= 1'b1;
							state         <= WRITE_BACK;
						end else begin
							mem_read_req <= 1'b1;
							state        <= READ;
						end
					end
				end
				WRITE_BACK: begin
					if (mem_write_ack) begin
						mem_write_req <= 1'b0;
						mem_read_req  <= 1'b1;
						state         <= READ;
					end
				end
				READ: begin
					if (mem_read_ack) begin
						mem_read_req <= 1'b0;
						state        <= FILL;
					end
				end
				FILL: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Payloads stay fixed for the whole miss
	always_ff @(posedge clk) begin
		if (start) begin
			victim_q    <= victim;
			mem_wr.addr <= wb_addr.raw;
			mem_wr.data <= victim_line;
			mem_rd.addr <= rd_addr.raw;
			fill_tag    <= req.addr.fields.tag;
			fill_index  <= req.addr.fields.index;
		end
		// Read data is only valid in the ack cycle
		if ((state == READ) && mem_read_ack)
			fill_line <= mem_read_data;
	end

endmodule

//--- design/cache_4way.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_4way (
	input  logic                          clk,
	input  logic                          reset,
	input  cache_pkg::cpu_req_t           req,
	input  logic                          master_enable,
	output logic [31:0]                   data_out,
	output logic                          hit,
	// Memory ports
	output logic                          mem_write_req,
	output cache_pkg::mem_wr_t            mem_wr,
	input  logic                          mem_write_ack,
	output logic                          mem_read_req,
	output cache_pkg::mem_rd_t            mem_rd,
	input  logic [`CACHE_LINE_BITS-1:0]   mem_read_data,
	input  logic                          mem_read_ack
);

	import cache_pkg::*;

	way_mask_t                      hit_mask;
	way_mask_t                      valid_mask;
	way_mask_t                      dirty_mask;
	way_mask_t                      victim;
	way_mask_t                      fill;
	logic [`CACHE_TAG_BITS-1:0]     way_tags  [4];
	logic [`CACHE_LINE_BITS-1:0]    way_lines [4];
	logic [31:0]                    way_words [4];

	logic                           any_hit;
	logic                           miss;
	logic [31:0]                    hit_word;
	logic                           victim_dirty;
	logic [`CACHE_TAG_BITS-1:0]     victim_tag;
	logic [`CACHE_LINE_BITS-1:0]    victim_line;
	logic [`CACHE_LINE_BITS-1:0]    fill_line;
	logic [`CACHE_TAG_BITS-1:0]     fill_tag;
	logic [`CACHE_INDEX_BITS-1:0]   fill_index;

	//////////////////////////////////////////////////////////////////////
	// Ways
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 4; i++) begin : way_gen
		cache_way way_inst (
			.clk        (clk),
			.reset      (reset),
			.req        (req),
			.access     (master_enable && hit_mask[i]),
			.fill       (fill[i]),
			.fill_line  (fill_line),
			.fill_tag   (fill_tag),
			.fill_index (fill_index),
			.way_hit    (hit_mask[i]),
			.way_valid  (valid_mask[i]),
			.way_dirty  (dirty_mask[i]),
			.way_tag    (way_tags[i]),
			.way_line   (way_lines[i]),
			.word_out   (way_words[i])
		);
	end

	assign any_hit = |hit_mask;
	assign miss    = master_enable && !any_hit;

	// Hit word and victim fields, both one-hot selects
	always_comb begin
		hit_word     = '0;
		victim_dirty = 1'b0;
		victim_tag   = '0;
		victim_line  = '0;
		for (int i = 0; i < 4; i++) begin
			if (hit_mask[i])
				hit_word = way_words[i];
			if (victim[i]) begin
				victim_dirty = dirty_mask[i];
				victim_tag   = way_tags[i];
				victim_line  = way_lines[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Replacement and miss handling
	//////////////////////////////////////////////////////////////////////

	plru_tree plru_inst (
		.clk        (clk),
		.reset      (reset),
		.index      (req.addr.fields.index),
		.touch      (master_enable && any_hit),
		.hit_ways   (hit_mask),
		.valid_ways (valid_mask),
		.victim     (victim)
	);

	miss_controller miss_inst (
		.clk           (clk),
		.reset         (reset),
		.req           (req),
		.miss          (miss),
		.victim        (victim),
		.victim_dirty  (victim_dirty),
		.victim_tag    (victim_tag),
		.victim_line   (victim_line),
		.mem_write_ack (mem_write_ack),
		.mem_read_ack  (mem_read_ack),
		.mem_read_data (mem_read_data),
		.mem_write_req (mem_write_req),
		.mem_wr        (mem_wr),
		.mem_read_req  (mem_read_req),
		.mem_rd        (mem_rd),
		.fill          (fill),
		.fill_line     (fill_line),
		.fill_tag      (fill_tag),
		.fill_index    (fill_index)
	);

	// Processor outputs, one cycle after the lookup
	always_ff @(posedge clk) begin
		if (reset)
			hit <= 1'b0;
		else
			hit <= master_enable && any_hit;
	end

	always_ff @(posedge clk) begin
		if (master_enable && any_hit)
			data_out <= hit_word;
	end

endmodule

//--- tests/cache_mem_model.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_mem_model (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          mem_write_req,
	input  cache_pkg::mem_wr_t            mem_wr,
	output logic                          mem_write_ack,
	input  logic                          mem_read_req,
	input  cache_pkg::mem_rd_t            mem_rd,
	output logic [`CACHE_LINE_BITS-1:0]   mem_read_data,
	output logic                          mem_read_ack,
	input  logic [31:0]                   peek_addr,
	output logic [31:0]                   peek_word
);

	// Lines written back so far; every other line follows the fill rule
	logic [`CACHE_LINE_BITS-1:0] lines [logic [31:0]];

	logic                        write_ack_q = 1'b0;
	logic                        read_ack_q  = 1'b0;
	logic [`CACHE_LINE_BITS-1:0] read_data_q = '0;
	logic [31:0]                 peek_q      = '0;
	int                          write_wait  = -1;
	int                          read_wait   = -1;

	assign mem_write_ack = write_ack_q;
	assign mem_read_ack  = read_ack_q;
	assign mem_read_data = read_data_q;
	assign peek_word     = peek_q;

	// Each word holds its own byte address XOR a fixed pattern
	function automatic logic [`CACHE_LINE_BITS-1:0] line_at(input logic [31:0] addr);
		logic [31:0] line_addr;
		line_addr = addr & 32'(~(`CACHE_LINE_BYTES - 1));
		if (lines.exists(line_addr))
			return lines[line_addr];
		return {(line_addr + 32'd4) ^ 32'h5a5a_0000, line_addr ^ 32'h5a5a_0000};
	endfunction

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		logic [`CACHE_LINE_BITS-1:0] line;
		line = line_at(addr);
		return addr[2] ? line[63:32] : line[31:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Request/ack handshakes with a random delay
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		peek_q <= word_at(peek_addr);
		if (reset) begin
			write_ack_q <= 1'b0;
			read_ack_q  <= 1'b0;
			write_wait  <= -1;
			read_wait   <= -1;
		end else begin
			// Ack cycle: the request is still seen high on this edge
			if (write_ack_q)
				write_ack_q <= 1'b0;
			else if (mem_write_req) begin
				if (write_wait < 0)
					write_wait <= $urandom_range(4, 1) - 1;
				else if (write_wait == 0) begin
					lines[mem_wr.addr] = mem_wr.data;
					write_ack_q <= 1'b1;
					write_wait  <= -1;
				end else
					write_wait <= write_wait - 1;
			end

			if (read_ack_q)
				read_ack_q <= 1'b0;
			else if (mem_read_req) begin
				if (read_wait < 0)
					read_wait <= $urandom_range(4, 1) - 1;
				else if (read_wait == 0) begin
					read_data_q <= line_at(mem_rd.addr);
					read_ack_q  <= 1'b1;
					read_wait   <= -1;
				end else
					read_wait <= read_wait - 1;
			end
		end
	end

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb;

	import cache_pkg::*;

	localparam int          CLK_HALF_NS      = 4;
	localparam int          RESET_CYCLES     = 5;
	localparam int          CYCLES_PER_ENTRY = 40;
	localparam logic [31:0] RAND_SEED        = 32'hb2ab_831d;

	localparam logic [3:0] OP_READ  = 4'h0;
	localparam logic [3:0] OP_WRITE = 4'h1;
	localparam logic [3:0] OP_RESET = 4'h2;
	localparam logic [3:0] OP_IDLE  = 4'h3;
	localparam logic [3:0] OP_PEEK  = 4'h4;

	// One trace line
	typedef struct packed {
		logic [3:0]  op;
		logic [31:0] addr;
		logic [3:0]  byte_en;
		logic [31:0] wdata;
		logic [31:0] expect_word;
		logic        miss;
	} trace_entry_t;

	logic                        clk;
	logic                        reset;
	cpu_req_t                    req;
	logic                        master_enable;
	logic [31:0]                 data_out;
	logic                        hit;
	logic                        mem_write_req;
	mem_wr_t                     mem_wr;
	logic                        mem_write_ack;
	logic                        mem_read_req;
	mem_rd_t                     mem_rd;
	logic [`CACHE_LINE_BITS-1:0] mem_read_data;
	logic                        mem_read_ack;
	logic [31:0]                 peek_addr;
	logic [31:0]                 peek_word;

	trace_entry_t trace_q [$];
	int           trace_len     = 0;
	int           read_starts   = 0;
	logic         read_req_seen = 1'b0;

	cache_4way cache_4way_inst (
		.clk           (clk),
		.reset         (reset),
		.req           (req),
		.master_enable (master_enable),
		.data_out      (data_out),
		.hit           (hit),
		.mem_write_req (mem_write_req),
		.mem_wr        (mem_wr),
		.mem_write_ack (mem_write_ack),
		.mem_read_req  (mem_read_req),
		.mem_rd        (mem_rd),
		.mem_read_data (mem_read_data),
		.mem_read_ack  (mem_read_ack)
	);

	cache_mem_model mem_model_inst (
		.clk           (clk),
		.reset         (reset),
		.mem_write_req (mem_write_req),
		.mem_wr        (mem_wr),
		.mem_write_ack (mem_write_ack),
		.mem_read_req  (mem_read_req),
		.mem_rd        (mem_rd),
		.mem_read_data (mem_read_data),
		.mem_read_ack  (mem_read_ack),
		.peek_addr     (peek_addr),
		.peek_word     (peek_word)
	);

	always #(CLK_HALF_NS) clk = ~clk;

	// Count each rising line read request
	always @(negedge clk) begin
		if (mem_read_req && !read_req_seen)
			read_starts = read_starts + 1;
		read_req_seen = mem_read_req;
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Trace loading
	//////////////////////////////////////////////////////////////////////

	task automatic load_trace();
		int           fd;
		int           fields;
		string        line;
		logic [31:0]  op_v;
		logic [31:0]  addr_v;
		logic [31:0]  be_v;
		logic [31:0]  wdata_v;
		logic [31:0]  expect_v;
		logic [31:0]  miss_v;
		trace_entry_t e;
		fd = $fopen("tests/cache_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/cache_trace.txt");
			abort_run();
		end
		while ($fgets(line, fd) > 0) begin
			// Blank lines and comments
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			fields = $sscanf(line, "%h %h %h %h %h %h",
				op_v, addr_v, be_v, wdata_v, expect_v, miss_v);
			if (fields != 6) begin
				$display("Trace line has %0d fields instead of 6: %s", fields, line);
				abort_run();
			end
			e.op          = op_v[3:0];
			e.addr        = addr_v;
			e.byte_en     = be_v[3:0];
			e.wdata       = wdata_v;
			e.expect_word = expect_v;
			e.miss        = miss_v[0];
			trace_q.push_back(e);
		end
		$fclose(fd);
		if (trace_q.size() == 0) begin
			$display("The trace file holds no requests");
			abort_run();
		end
		trace_len = trace_q.size();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Trace operations
	//////////////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clk);
		reset         <= 1'b1;
		master_enable <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!hit && !mem_read_req && !mem_write_req)
		else begin
			$display("Error: %0t hit or memory request still high after reset", $time);
			abort_run();
		end
	endtask

	task automatic run_access(input trace_entry_t e);
		cpu_req_t r;
		int       reads_before;
		r.addr.raw = e.addr;
		r.write    = (e.op == OP_WRITE);
		r.byte_en  = e.byte_en;
		r.wdata    = e.wdata;
		@(posedge clk);
		reads_before   = read_starts;
		req           <= r;
		master_enable <= 1'b1;
		// A miss takes as long as memory needs
		@(negedge clk);
		while (!hit)
			@(negedge clk);
		assert (data_out == e.expect_word)
		else begin
			$display("Error: %0t address %h returned %h, expected %h",
				$time, e.addr, data_out, e.expect_word);
			abort_run();
		end
		@(posedge clk);
		master_enable <= 1'b0;
		assert ((read_starts - reads_before) == int'(e.miss))
		else begin
			$display("Error: %0t address %h caused %0d line reads, expected %0d",
				$time, e.addr, read_starts - reads_before, e.miss);
			abort_run();
		end
		// Enable was still high on this edge, so the hit repeats once
		@(negedge clk);
		assert (hit && data_out == e.expect_word)
		else begin
			$display("Error: %0t repeated hit missing or changed for address %h",
				$time, e.addr);
			abort_run();
		end
		@(negedge clk);
		assert (!hit)
		else begin
			$display("Error: %0t hit stays high after master_enable dropped", $time);
			abort_run();
		end
	endtask

	task automatic hold_enable_low(input trace_entry_t e);
		cpu_req_t r;
		int       reads_before;
		r          = '0;
		r.addr.raw = e.addr;
		@(posedge clk);
		reads_before   = read_starts;
		req           <= r;
		master_enable <= 1'b0;
		repeat (e.wdata) begin
			@(negedge clk);
			assert (!hit && !mem_read_req && !mem_write_req)
			else begin
				$display("Error: %0t activity while master_enable is low", $time);
				abort_run();
			end
		end
		assert (read_starts == reads_before)
		else begin
			$display("Error: %0t line read started while idle", $time);
			abort_run();
		end
	endtask

	task automatic check_memory(input trace_entry_t e);
		@(posedge clk);
		peek_addr <= e.addr;
		@(posedge clk);
		@(negedge clk);
		assert (peek_word == e.expect_word)
		else begin
			$display("Error: %0t memory word %h holds %h, expected %h",
				$time, e.addr, peek_word, e.expect_word);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		master_enable = 1'b0;
		req           = '0;
		peek_addr     = '0;
		void'($urandom(RAND_SEED));
		load_trace();
		apply_reset();
		foreach (trace_q[i]) begin
			case (trace_q[i].op)
				OP_READ, OP_WRITE: run_access(trace_q[i]);
				OP_RESET:          apply_reset();
				OP_IDLE:           hold_enable_low(trace_q[i]);
				OP_PEEK:           check_memory(trace_q[i]);
				default: begin
					$display("Unknown operation %h in trace entry %0d",
						trace_q[i].op, i);
					abort_run();
				end
			endcase
		end
		@(posedge clk);
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		wait (trace_len > 0);
		repeat (RESET_CYCLES + trace_len * CYCLES_PER_ENTRY) @(posedge clk);
		$display("Timeout: the trace did not finish within %0d cycles",
			RESET_CYCLES + trace_len * CYCLES_PER_ENTRY);
		abort_run();
	end

endmodule

//--- compile.f
+incdir+include
design/cache_pkg.sv
design/cache_way.sv
design/plru_tree.sv
design/miss_controller.sv
design/cache_4way.sv
tests/cache_mem_model.sv
tests/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it, and judge the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module cache_tb -o Vcache_tb

# The simulator exits non-zero on a fatal error; the log decides the result
./obj_dir/Vcache_tb 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "Simulation reported errors"
	exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"

//--- tests/cache_trace.txt
# op addr byte_en wdata expect miss, all hex
# op: 0 read, 1 write, 2 reset, 3 idle for wdata cycles, 4 check memory word
0 00001008 0 00000000 5a5a1008 1
0 00001008 0 00000000 5a5a1008 0
0 0000100c 0 00000000 5a5a100c 0
1 0000100c 3 deadbeef 5a5abeef 0
0 00001008 0 00000000 5a5a1008 0
0 0000100c 0 00000000 5a5abeef 0
# Five tags at index 0, the first one dirty
1 00002000 f 11112222 11112222 1
0 00002020 0 00000000 5a5a2020 1
0 00002040 0 00000000 5a5a2040 1
0 00002060 0 00000000 5a5a2060 1
0 00002080 0 00000000 5a5a2080 1
4 00002000 0 00000000 11112222 0
4 00002004 0 00000000 5a5a2004 0
0 00002000 0 00000000 11112222 1
# Touch ways 1, 2 and 3, then a new tag replaces way 0
0 00002020 0 00000000 5a5a2020 0
0 00002000 0 00000000 11112222 0
0 00002060 0 00000000 5a5a2060 0
0 000020a0 0 00000000 5a5a20a0 1
0 00002020 0 00000000 5a5a2020 0
0 00002000 0 00000000 11112222 0
0 00002060 0 00000000 5a5a2060 0
0 00002080 0 00000000 5a5a2080 1
1 00003018 1 000000ff 5a5a30ff 1
3 00004000 0 00000006 00000000 0
# Reset drops the cache contents, memory keeps the write-back
2 00000000 0 00000000 00000000 0
0 0000100c 0 00000000 5a5a100c 1
0 00002000 0 00000000 11112222 1
1 00002004 c abcd0000 abcd2004 0
0 00002000 0 00000000 11112222 0
0 00002004 0 00000000 abcd2004 0
